/* Bender.yml */
package:
  name: ahb_buf

sources:
  # package first, then leaf blocks, then the top level
  - design/ahb_buf_pkg.sv
  - design/ahb_swc.sv
  - design/wr_buffer.sv
  - design/word_store.sv
  - design/rd_merge.sv
  - design/ahb_buf_top.sv

  # testbench, top module tb_ahb_buf
  - target: test
    files:
      - tests/tb_ahb_buf.sv

/* build.f */
design/ahb_buf_pkg.sv
design/ahb_swc.sv
design/wr_buffer.sv
design/word_store.sv
design/rd_merge.sv
design/ahb_buf_top.sv
tests/tb_ahb_buf.sv

/* design/ahb_buf_pkg.sv */
package ahb_buf_pkg;

	// bus widths
	localparam int data_w = 32;
	localparam int addr_w = 32;

	// storage array geometry
	localparam int store_words = 16;
	localparam int word_idx_w  = 4;

	// posted-write buffer geometry
	localparam int buf_depth = 4;
	localparam int buf_ptr_w = 2;

	// array decodes from here upward, one word per 4 bytes
	localparam logic [addr_w-1:0] store_base = 32'h0000_0000;

	// htrans codes
	localparam logic [1:0] htrans_idle   = 2'b00;
	localparam logic [1:0] htrans_busy   = 2'b01;
	localparam logic [1:0] htrans_nonseq = 2'b10;
	localparam logic [1:0] htrans_seq    = 2'b11;

	// only 32-bit transfers are supported
	localparam logic [2:0] hsize_word = 3'b010;

	typedef logic [data_w-1:0]     bus_word_t;
	typedef logic [addr_w-1:0]     bus_addr_t;
	typedef logic [word_idx_w-1:0] word_idx_t;

	// slave controller states
	// err1/err2 are the two cycles of the AHB error response
	typedef enum logic [2:0] {
		st_idle,
		st_read,
		st_write,
		st_err1,
		st_err2
	} swc_state_t;

endpackage

/* design/ahb_buf_top.sv */
`timescale 1ns/1ps

module ahb_buf_top (
	input  logic                   hclk,
	input  logic                   hrstn,
	input  ahb_buf_pkg::bus_addr_t haddr,
	input  logic                   hwrite,
	input  logic [1:0]             htrans,
	input  logic [2:0]             hsize,
	// accepted, not used
	input  logic [3:0]             hprot,
	input  logic                   hmastlock,
	input  ahb_buf_pkg::bus_word_t hwdata,
	output ahb_buf_pkg::bus_word_t hrdata,
	output logic                   hready,
	output logic                   hresp
);

	import ahb_buf_pkg::*;

	// controller to buffer
	logic      wreq;
	word_idx_t wbuffidx;
	bus_word_t wbuffdata;
	logic      buf_full;

	// read path
	logic      rreq;
	word_idx_t rbuffidx;
	bus_word_t rbuffdata;
	bus_word_t store_rdata;
	logic      fwd_hit;
	bus_word_t fwd_data;

	// buffer drain into array
	logic      st_we;
	word_idx_t st_widx;
	bus_word_t st_wdata;

	ahb_swc i_swc (
		.hclk      (hclk),
		.hrstn     (hrstn),
		.haddr     (haddr),
		.hwrite    (hwrite),
		.htrans    (htrans),
		.hsize     (hsize),
		.hwdata    (hwdata),
		.hrdata    (hrdata),
		.hready    (hready),
		.hresp     (hresp),
		.buf_full  (buf_full),
		.wreq      (wreq),
		.wbuffidx  (wbuffidx),
		.wbuffdata (wbuffdata),
		.rreq      (rreq),
		.rbuffidx  (rbuffidx),
		.rbuffdata (rbuffdata)
	);

	wr_buffer i_wbuf (
		.hclk      (hclk),
		.hrstn     (hrstn),
		.wreq      (wreq),
		.wbuffidx  (wbuffidx),
		.wbuffdata (wbuffdata),
		.buf_full  (buf_full),
		.st_we     (st_we),
		.st_widx   (st_widx),
		.st_wdata  (st_wdata),
		.rbuffidx  (rbuffidx),
		.fwd_hit   (fwd_hit),
		.fwd_data  (fwd_data)
	);

	word_store i_store (
		.hclk        (hclk),
		.hrstn       (hrstn),
		.st_we       (st_we),
		.st_widx     (st_widx),
		.st_wdata    (st_wdata),
		.rbuffidx    (rbuffidx),
		.store_rdata (store_rdata)
	);

	rd_merge i_merge (
		.rreq        (rreq),
		.fwd_hit     (fwd_hit),
		.fwd_data    (fwd_data),
		.store_rdata (store_rdata),
		.rbuffdata   (rbuffdata)
	);

endmodule

/* design/ahb_swc.sv */
`timescale 1ns/1ps

module ahb_swc (
	input  logic                  hclk,
	input  logic                  hrstn,
	// ahb-lite slave side
	input  ahb_buf_pkg::bus_addr_t haddr,
	input  logic                  hwrite,
	input  logic [1:0]            htrans,
	input  logic [2:0]            hsize,
	input  ahb_buf_pkg::bus_word_t hwdata,
	output ahb_buf_pkg::bus_word_t hrdata,
	output logic                  hready,
	output logic                  hresp,
	// write buffer side
	input  logic                  buf_full,
	output logic                  wreq,
	output ahb_buf_pkg::word_idx_t wbuffidx,
	output ahb_buf_pkg::bus_word_t wbuffdata,
	// read side
	output logic                  rreq,
	output ahb_buf_pkg::word_idx_t rbuffidx,
	input  ahb_buf_pkg::bus_word_t rbuffdata
);

	import ahb_buf_pkg::*;

	swc_state_t state_q;
	swc_state_t state_d;
	// state the current address phase asks for
	swc_state_t phase_next;

	bus_addr_t addr_off;
	logic      addr_ok;
	logic      size_ok;
	logic      addr_accept;
	word_idx_t addr_idx;
	// word index of the transfer now in its data phase
	word_idx_t idx_q;

	// address decode, relative to array base
	assign addr_off = haddr - store_base;
	assign addr_ok  = (addr_off < bus_addr_t'(store_words * 4));
	assign size_ok  = (hsize == hsize_word);
	assign addr_idx = addr_off[word_idx_w+1:2];

	// decode of whatever the master presents this cycle
	always_comb begin
		phase_next = st_idle;
		case (htrans)
			htrans_nonseq,
			htrans_seq: begin
				// seq handled just like nonseq
				if (!addr_ok || !size_ok)
					phase_next = st_err1;
				else if (hwrite)
					phase_next = st_write;
				else
					phase_next = st_read;
			end
			htrans_idle,
			htrans_busy: begin
				// busy counts as idle
				phase_next = st_idle;
			end
		endcase
	end

	// address phase only taken while hready high
	always_comb begin
		state_d = state_q;
		case (state_q)
			st_err1: begin
				// hready low here, address phase held off
				state_d = st_err2;
			end
			st_write: begin
				// full buffer stretches the write data phase
				if (!buf_full)
					state_d = phase_next;
			end
			default: begin
				state_d = phase_next;
			end
		endcase
	end

	always_ff @(posedge hclk) begin
		if (!hrstn) begin
			state_q <= st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// good read or write seen in an accepted address phase
	assign addr_accept = hready && ((phase_next == st_read) || (phase_next == st_write));

	// index kept for the data phase
	always_ff @(posedge hclk) begin
		if (addr_accept)
			idx_q <= addr_idx;
	end

	// wait only on a full buffer or first error cycle
	assign hready = !(((state_q == st_write) && buf_full) || (state_q == st_err1));
	assign hresp  = (state_q == st_err1) || (state_q == st_err2);

	// push goes out the cycle hwdata is valid
	assign wreq      = (state_q == st_write) && !buf_full;
	assign wbuffidx  = idx_q;
	assign wbuffdata = hwdata;

	// read data phase, zero wait
	assign rreq     = (state_q == st_read);
	assign rbuffidx = idx_q;
	// merge already returns zero outside reads
	assign hrdata   = rbuffdata;

endmodule

/* design/rd_merge.sv */
`timescale 1ns/1ps

module rd_merge (
	input  logic                   rreq,
	// from the write buffer lookup
	input  logic                   fwd_hit,
	input  ahb_buf_pkg::bus_word_t fwd_data,
	// from the storage array
	input  ahb_buf_pkg::bus_word_t store_rdata,
	output ahb_buf_pkg::bus_word_t rbuffdata
);

	// pending write is newer than the array copy
	// idle bus sees zero so hrdata stays quiet
	always_comb begin
		case ({rreq, fwd_hit})
			2'b11:   rbuffdata = fwd_data;
			2'b10:   rbuffdata = store_rdata;
			default: rbuffdata = '0;
		endcase
	end

endmodule

/* design/word_store.sv */
`timescale 1ns/1ps

module word_store (
	input  logic                   hclk,
	input  logic                   hrstn,
	// write port, fed by the buffer drain
	input  logic                   st_we,
	input  ahb_buf_pkg::word_idx_t st_widx,
	input  ahb_buf_pkg::bus_word_t st_wdata,
	// async read port
	input  ahb_buf_pkg::word_idx_t rbuffidx,
	output ahb_buf_pkg::bus_word_t store_rdata
);

	import ahb_buf_pkg::*;

	bus_word_t mem [store_words];

	// whole array comes up zeroed
	always_ff @(posedge hclk) begin
		if (!hrstn) begin
			for (int i = 0; i < store_words; i++)
				mem[i] <= '0;
		end else if (st_we) begin
			mem[st_widx] <= st_wdata;
		end
	end

	// read in the same cycle as the index
	assign store_rdata = mem[rbuffidx];

endmodule

/* design/wr_buffer.sv */
`timescale 1ns/1ps

module wr_buffer (
	input  logic                   hclk,
	input  logic                   hrstn,
	// push side from the controller
	input  logic                   wreq,
	input  ahb_buf_pkg::word_idx_t wbuffidx,
	input  ahb_buf_pkg::bus_word_t wbuffdata,
	output logic                   buf_full,
	// drain side into the array
	output logic                   st_we,
	output ahb_buf_pkg::word_idx_t st_widx,
	output ahb_buf_pkg::bus_word_t st_wdata,
	// forwarding lookup
	input  ahb_buf_pkg::word_idx_t rbuffidx,
	output logic                   fwd_hit,
	output ahb_buf_pkg::bus_word_t fwd_data
);

	import ahb_buf_pkg::*;

	// entry storage, index and data side by side
	word_idx_t idx_mem  [buf_depth];
	bus_word_t data_mem [buf_depth];

	logic [buf_ptr_w-1:0] wr_ptr;
	logic [buf_ptr_w-1:0] rd_ptr;
	// one extra bit so full and empty differ
	logic [buf_ptr_w:0]   count;

	logic push;
	logic pop;

	assign push = wreq;
	// drain every cycle there is something
	assign pop  = (count != '0);

	assign buf_full = (count == (buf_ptr_w + 1)'(buf_depth));

	// head of queue straight to the array
	assign st_we    = pop;
	assign st_widx  = idx_mem[rd_ptr];
	assign st_wdata = data_mem[rd_ptr];

	// entry payload
	always_ff @(posedge hclk) begin
		if (push) begin
			idx_mem[wr_ptr]  <= wbuffidx;
			data_mem[wr_ptr] <= wbuffdata;
		end
	end

	// pointers and occupancy
	always_ff @(posedge hclk) begin
		if (!hrstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// youngest matching entry wins
	// walk oldest to youngest, later hits overwrite earlier ones
	// head being drained this cycle still counts
	always_comb begin
		logic [buf_ptr_w-1:0] slot;
		fwd_hit  = 1'b0;
		fwd_data = '0;
		for (int i = 0; i < buf_depth; i++) begin
			slot = rd_ptr + buf_ptr_w'(i);
			if ((i < int'(count)) && (idx_mem[slot] == rbuffidx)) begin
				fwd_hit  = 1'b1;
				fwd_data = data_mem[slot];
			end
		end
	end

endmodule

/* tests/tb_ahb_buf.sv */
`timescale 1ns/1ps

module tb_ahb_buf;

	import ahb_buf_pkg::*;

	// transfers per test, sets the watchdog budget
	localparam int n_xfers = 17 + 6 + 37 + 17 + 21 + 21;
	localparam int wd_cycles = n_xfers * 20 + 200;

	// what the previous transfer expects in its data phase
	localparam int dp_none  = 0;
	localparam int dp_read  = 1;
	localparam int dp_write = 2;
	localparam int dp_err   = 3;

	logic       hclk;
	logic       hrstn;
	bus_addr_t  haddr;
	logic       hwrite;
	logic [1:0] htrans;
	logic [2:0] hsize;
	logic [3:0] hprot;
	logic       hmastlock;
	bus_word_t  hwdata;
	bus_word_t  hrdata;
	logic       hready;
	logic       hresp;

	// expected array contents, updated when a write completes
	bus_word_t shadow [store_words];
	// transfer now sitting in its data phase
	int        dp_kind;
	word_idx_t dp_idx;
	bus_word_t dp_wdata;
	int        stall_cnt;
	integer    seed;

	ahb_buf_top i_dut (
		.hclk      (hclk),
		.hrstn     (hrstn),
		.haddr     (haddr),
		.hwrite    (hwrite),
		.htrans    (htrans),
		.hsize     (hsize),
		.hprot     (hprot),
		.hmastlock (hmastlock),
		.hwdata    (hwdata),
		.hrdata    (hrdata),
		.hready    (hready),
		.hresp     (hresp)
	);

	always #5 hclk = ~hclk;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	// error response, first cycle waits and second completes
	assert property (@(posedge hclk) disable iff (!hrstn) (hresp && !hready) |=> (hresp && hready))
		else stop_on_error($sformatf("Error at %0t: error response cut short", $time));
	assert property (@(posedge hclk) disable iff (!hrstn)
			(hresp && hready) |-> $past(hresp && !hready))
		else stop_on_error($sformatf("Error at %0t: error completed without wait cycle", $time));

	// sampled at negedge, all outputs settled
	task automatic check_data_phase(input int waits);
		case (dp_kind)
			dp_read: begin
				assert (hready && !hresp)
					else stop_on_error($sformatf("Error at %0t: read phase hready %b hresp %b",
						$time, hready, hresp));
				assert (hrdata === shadow[dp_idx])
					else stop_on_error($sformatf("Error at %0t: word %0d read %h, expected %h",
						$time, dp_idx, hrdata, shadow[dp_idx]));
			end
			dp_write: begin
				assert (!hresp)
					else stop_on_error($sformatf("Error at %0t: hresp set on good write",
						$time));
				if (hready)
					shadow[dp_idx] = dp_wdata;
				else
					stall_cnt++;
			end
			dp_err: begin
				assert (hresp && (hready == (waits != 0)))
					else stop_on_error($sformatf("Error at %0t: error cycle %0d hready %b hresp %b",
						$time, waits, hready, hresp));
			end
			default: begin
				assert (hready && !hresp)
					else stop_on_error($sformatf("Error at %0t: idle phase hready %b hresp %b",
						$time, hready, hresp));
			end
		endcase
	endtask

	// one address phase, overlapped with the previous data phase
	task automatic do_xfer(input logic [1:0] trans, input logic write, input bus_addr_t addr,
			input logic [2:0] size, input bus_word_t wdata);
		int   waits;
		logic done;
		logic bad;
		htrans = trans;
		hwrite = write;
		haddr  = addr;
		hsize  = size;
		hwdata = dp_wdata;
		waits  = 0;
		done   = 1'b0;
		// address held until hready
		while (!done) begin
			@(negedge hclk);
			check_data_phase(waits);
			if (hready)
				done = 1'b1;
			else
				waits++;
			@(posedge hclk);
			#1;
		end
		bad = ((addr - store_base) >= 32'(store_words * 4)) || (size != hsize_word);
		if ((trans == htrans_nonseq) || (trans == htrans_seq)) begin
			if (bad)
				dp_kind = dp_err;
			else if (write)
				dp_kind = dp_write;
			else
				dp_kind = dp_read;
		end else begin
			dp_kind = dp_none;
		end
		dp_idx   = addr[5:2];
		dp_wdata = wdata;
	endtask

	task automatic write_word(input int idx, input bus_word_t data);
		do_xfer(htrans_nonseq, 1'b1, store_base + bus_addr_t'(idx * 4), hsize_word, data);
	endtask

	task automatic read_word(input int idx);
		do_xfer(htrans_nonseq, 1'b0, store_base + bus_addr_t'(idx * 4), hsize_word, '0);
	endtask

	task automatic idle_cycle();
		do_xfer(htrans_idle, 1'b0, store_base, hsize_word, '0);
	endtask

	task automatic read_all();
		for (int i = 0; i < store_words; i++)
			read_word(i);
	endtask

	initial begin
		seed      = 32'hb90;
		hclk      = 1'b0;
		hrstn     = 1'b0;
		haddr     = '0;
		hwrite    = 1'b0;
		htrans    = htrans_idle;
		hsize     = hsize_word;
		hprot     = 4'b0011;
		hmastlock = 1'b0;
		hwdata    = '0;
		dp_kind   = dp_none;
		dp_idx    = '0;
		dp_wdata  = '0;
		stall_cnt = 0;
		for (int i = 0; i < store_words; i++)
			shadow[i] = '0;
		repeat (2) @(posedge hclk);
		#1;
		hrstn = 1'b1;

		// reset values, then every word reads zero
		@(negedge hclk);
		assert (hready && !hresp && (hrdata === '0))
			else stop_on_error($sformatf("Error at %0t: bad outputs after reset", $time));
		@(posedge hclk);
		#1;
		read_all();
		idle_cycle();

		// forwarding, youngest pending write wins
		write_word(3, $random(seed));
		read_word(3);
		write_word(3, $random(seed));
		write_word(3, $random(seed));
		read_word(3);
		idle_cycle();

		// fill every word, let the buffer drain, read back
		for (int i = 0; i < store_words; i++)
			write_word(i, $random(seed));
		repeat (4) idle_cycle();
		read_all();
		idle_cycle();

		// long write burst, seq after the first beat
		for (int i = 0; i < 8; i++)
			do_xfer((i == 0) ? htrans_nonseq : htrans_seq, 1'b1,
				store_base + bus_addr_t'(((i * 5) % store_words) * 4), hsize_word, $random(seed));
		for (int i = 0; i < 8; i++)
			read_word((i * 5) % store_words);
		idle_cycle();
		$display("burst done, %0d write stall cycles", stall_cnt);

		// out of range and halfword, storage must not change
		do_xfer(htrans_nonseq, 1'b1, store_base + 32'h40, hsize_word, $random(seed));
		do_xfer(htrans_nonseq, 1'b1, 32'h0000_1000, hsize_word, $random(seed));
		do_xfer(htrans_nonseq, 1'b1, store_base + 32'h8, 3'b001, $random(seed));
		do_xfer(htrans_nonseq, 1'b0, store_base + 32'h44, hsize_word, '0);
		read_all();
		idle_cycle();

		// idle and busy carry write data that must be dropped
		do_xfer(htrans_idle, 1'b1, store_base, hsize_word, $random(seed));
		do_xfer(htrans_busy, 1'b1, store_base + 32'h4, hsize_word, $random(seed));
		do_xfer(htrans_busy, 1'b1, store_base + 32'h8, hsize_word, $random(seed));
		do_xfer(htrans_idle, 1'b1, store_base + 32'hc, hsize_word, $random(seed));
		read_all();
		idle_cycle();

		$display("PASS: all tests");
		$finish;
	end

	// watchdog
	initial begin
		repeat (wd_cycles) @(posedge hclk);
		stop_on_error($sformatf("watchdog expired after %0d cycles, the bus never finished",
			wd_cycles));
	end

endmodule
